//--- common/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    localparam int STEP_WIDTH  = 2;
    localparam int FETCH_STEPS = 4; // Memory latency covered here
    localparam int SLL_STEPS   = 3;
    localparam int BREAK_STEPS = 2;

    typedef enum logic [5:0] {
        opTypeR = 6'b000000,
        opAddi  = 6'b001000,
        opAddiu = 6'b001001
    } opcode_t;

    typedef enum logic [5:0] {
        fnSll   = 6'b000000,
        fnBreak = 6'b001101,
        fnMfhi  = 6'b010000,
        fnMflo  = 6'b010010,
        fnAdd   = 6'b100000,
        fnSub   = 6'b100010,
        fnAnd   = 6'b100100
    } funct_t;

    typedef enum logic [3:0] {
        clsAdd, clsSub, clsAnd, clsSll, clsMfhi, clsMflo, clsBreak,
        clsAddi, clsAddiu, clsIllegal
    } instrClass_t;

    typedef enum logic [4:0] {
        stResetInit, stFetch, stPrecalc, stPrecalc2,
        stAdd, stSub, stAnd, stSaveResult,
        stAddi, stAddiu, stImmWriteBack,
        stSll, stMfhi, stMflo, stBreak,
        stOverflow, stOpcodeError
    } ctrlState_t;

    typedef enum logic [2:0] {
        aluPass      = 3'd0,
        aluAdd       = 3'd1,
        aluSub       = 3'd2,
        aluAnd       = 3'd3,
        aluShiftPass = 3'd4
    } aluOp_t;

    typedef enum logic [1:0] {
        srcPc   = 2'd0,
        srcRegA = 2'd1
    } aluSrcA_t;

    typedef enum logic [2:0] {
        srcRegB      = 3'd0,
        srcFour      = 3'd1,
        srcBranchOff = 3'd2,
        srcSignImm   = 3'd3
    } aluSrcB_t;

    typedef enum logic [1:0] {
        dstRd       = 2'd0,
        dstStackPtr = 2'd1,
        dstRt       = 2'd3
    } regDst_t;

    typedef enum logic [2:0] {
        dataAluOut    = 3'd0,
        dataLo        = 3'd1,
        dataHi        = 3'd2,
        dataStackInit = 3'd3,
        dataShifter   = 3'd6
    } dataSrc_t;

    typedef enum logic [2:0] {
        shiftHold = 3'd0,
        shiftLoad = 3'd1,
        shiftLeft = 3'd2
    } shiftOp_t;

    typedef enum logic [1:0] {
        amtNone  = 2'd0,
        amtShamt = 2'd2 // shamt field of the instruction
    } shiftAmtSrc_t;

endpackage

`default_nettype wire

//--- common/datapathCtrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface datapathCtrlIf (input wire logic clk);
    logic                  writePc, writeA, writeB;
    logic                  writeAluOut, writeInstr, writeReg;
    ctrlPkg::aluOp_t       aluCtrl;
    ctrlPkg::aluSrcA_t     aluSrcA;
    ctrlPkg::aluSrcB_t     aluSrcB;
    ctrlPkg::regDst_t      regDst;
    ctrlPkg::dataSrc_t     dataSrc;
    ctrlPkg::shiftOp_t     shiftCtrl;
    ctrlPkg::shiftAmtSrc_t shiftAmtSrc;

    modport source (input clk,
                    output writePc, writeA, writeB, writeAluOut, writeInstr, writeReg,
                    output aluCtrl, aluSrcA, aluSrcB, regDst, dataSrc, shiftCtrl, shiftAmtSrc);

    modport sink (input writePc, writeA, writeB, writeAluOut, writeInstr, writeReg,
                  input aluCtrl, aluSrcA, aluSrcB, regDst, dataSrc, shiftCtrl, shiftAmtSrc);
endinterface

`default_nettype wire

//--- control/ctrlFsm.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlFsm (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire ctrlPkg::instrClass_t  instrClass,
    input  wire logic                  overflow,
    input  wire logic                  stepLast,
    output ctrlPkg::ctrlState_t        state,
    output ctrlPkg::ctrlState_t        nextState,
    output logic                       overflowTrap,
    output logic                       opcodeError
);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ctrlPkg::stResetInit; // Stack pointer write follows
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            ctrlPkg::stResetInit: nextState = ctrlPkg::stFetch;
            ctrlPkg::stFetch: begin
                if (stepLast) begin
                    nextState = ctrlPkg::stPrecalc;
                end
            end
            ctrlPkg::stPrecalc: nextState = ctrlPkg::stPrecalc2;
            ctrlPkg::stPrecalc2: begin
                case (instrClass)
                    ctrlPkg::clsAdd:   nextState = ctrlPkg::stAdd;
                    ctrlPkg::clsSub:   nextState = ctrlPkg::stSub;
                    ctrlPkg::clsAnd:   nextState = ctrlPkg::stAnd;
                    ctrlPkg::clsSll:   nextState = ctrlPkg::stSll;
                    ctrlPkg::clsMfhi:  nextState = ctrlPkg::stMfhi;
                    ctrlPkg::clsMflo:  nextState = ctrlPkg::stMflo;
                    ctrlPkg::clsBreak: nextState = ctrlPkg::stBreak;
                    ctrlPkg::clsAddi:  nextState = ctrlPkg::stAddi;
                    ctrlPkg::clsAddiu: nextState = ctrlPkg::stAddiu;
                    default:           nextState = ctrlPkg::stOpcodeError;
                endcase
            end
            ctrlPkg::stAdd, ctrlPkg::stSub, ctrlPkg::stAnd: begin
                nextState = ctrlPkg::stSaveResult;
            end
            ctrlPkg::stSaveResult: begin
                nextState = overflow ? ctrlPkg::stOverflow : ctrlPkg::stFetch;
            end
            ctrlPkg::stAddi: begin
                nextState = overflow ? ctrlPkg::stOverflow : ctrlPkg::stImmWriteBack;
            end
            ctrlPkg::stAddiu: nextState = ctrlPkg::stImmWriteBack; // No trap on addiu
            ctrlPkg::stImmWriteBack: nextState = ctrlPkg::stFetch;
            ctrlPkg::stSll, ctrlPkg::stBreak: begin
                if (stepLast) begin
                    nextState = ctrlPkg::stFetch;
                end
            end
            ctrlPkg::stMfhi, ctrlPkg::stMflo: nextState = ctrlPkg::stFetch;
            ctrlPkg::stOverflow, ctrlPkg::stOpcodeError: nextState = state; // Held until reset
            default: nextState = ctrlPkg::stOpcodeError;
        endcase
    end

    assign overflowTrap = (state == ctrlPkg::stOverflow);
    assign opcodeError  = (state == ctrlPkg::stOpcodeError);

    stateLegal: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state) && (state <= ctrlPkg::stOpcodeError));

    // Only the two trapping adds may lead into the overflow trap
    overflowEntry: assert property (@(posedge clk) disable iff (reset)
        (state == ctrlPkg::stOverflow) && ($past(state) != ctrlPkg::stOverflow)
        |-> ($past(state) inside {ctrlPkg::stSaveResult, ctrlPkg::stAddi}));

endmodule

`default_nettype wire

//--- control/ctrlOutputs.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlOutputs (
    input  wire ctrlPkg::ctrlState_t             state,
    input  wire logic [ctrlPkg::STEP_WIDTH-1:0]  step,
    datapathCtrlIf.source                        ctrl
);

    always_comb begin
        ctrl.writePc     = 1'b0;
        ctrl.writeA      = 1'b0;
        ctrl.writeB      = 1'b0;
        ctrl.writeAluOut = 1'b0;
        ctrl.writeInstr  = 1'b0;
        ctrl.writeReg    = 1'b0;
        ctrl.aluCtrl     = ctrlPkg::aluPass;
        ctrl.aluSrcA     = ctrlPkg::srcPc;
        ctrl.aluSrcB     = ctrlPkg::srcRegB;
        ctrl.regDst      = ctrlPkg::dstRd;
        ctrl.dataSrc     = ctrlPkg::dataAluOut;
        ctrl.shiftCtrl   = ctrlPkg::shiftHold;
        ctrl.shiftAmtSrc = ctrlPkg::amtNone;

        case (state)
            ctrlPkg::stResetInit: begin
                ctrl.writeReg = 1'b1;
                ctrl.regDst   = ctrlPkg::dstStackPtr;
                ctrl.dataSrc  = ctrlPkg::dataStackInit;
            end
            ctrlPkg::stFetch: begin
                if (step == ctrlPkg::STEP_WIDTH'(ctrlPkg::FETCH_STEPS - 1)) begin
                    ctrl.writePc = 1'b1;
                end else begin
                    ctrl.writeInstr  = 1'b1; // Memory still settling
                    ctrl.writeAluOut = 1'b1;
                    ctrl.aluSrcB     = ctrlPkg::srcFour;
                    ctrl.aluCtrl     = ctrlPkg::aluAdd;
                end
            end
            ctrlPkg::stPrecalc: begin
                ctrl.writeAluOut = 1'b1; // Branch target, speculatively
                ctrl.aluSrcB     = ctrlPkg::srcBranchOff;
                ctrl.aluCtrl     = ctrlPkg::aluAdd;
            end
            ctrlPkg::stPrecalc2: begin
                ctrl.writeA = 1'b1;
                ctrl.writeB = 1'b1;
            end
            ctrlPkg::stAdd, ctrlPkg::stSub, ctrlPkg::stAnd: begin
                ctrl.writeAluOut = 1'b1;
                ctrl.aluSrcA     = ctrlPkg::srcRegA;
                ctrl.aluSrcB     = ctrlPkg::srcRegB;
                if (state == ctrlPkg::stAdd) begin
                    ctrl.aluCtrl = ctrlPkg::aluAdd;
                end else if (state == ctrlPkg::stSub) begin
                    ctrl.aluCtrl = ctrlPkg::aluSub;
                end else begin
                    ctrl.aluCtrl = ctrlPkg::aluAnd;
                end
            end
            ctrlPkg::stSaveResult: ctrl.writeReg = 1'b1;
            ctrlPkg::stAddi, ctrlPkg::stAddiu: begin
                ctrl.writeAluOut = 1'b1;
                ctrl.aluSrcA     = ctrlPkg::srcRegA;
                ctrl.aluSrcB     = ctrlPkg::srcSignImm;
                ctrl.aluCtrl     = ctrlPkg::aluAdd;
            end
            ctrlPkg::stImmWriteBack: begin
                ctrl.writeReg = 1'b1;
                ctrl.regDst   = ctrlPkg::dstRt;
            end
            ctrlPkg::stSll: begin
                ctrl.aluCtrl     = ctrlPkg::aluShiftPass;
                ctrl.shiftAmtSrc = ctrlPkg::amtShamt;
                ctrl.shiftCtrl   = (step == '0) ? ctrlPkg::shiftLoad : ctrlPkg::shiftLeft;
                if (step == ctrlPkg::STEP_WIDTH'(ctrlPkg::SLL_STEPS - 1)) begin
                    ctrl.writeReg = 1'b1;
                    ctrl.dataSrc  = ctrlPkg::dataShifter;
                end
            end
            ctrlPkg::stMfhi: begin
                ctrl.writeReg = 1'b1;
                ctrl.dataSrc  = ctrlPkg::dataHi;
            end
            ctrlPkg::stMflo: begin
                ctrl.writeReg = 1'b1;
                ctrl.dataSrc  = ctrlPkg::dataLo;
            end
            ctrlPkg::stBreak: begin
                if (step == '0) begin
                    ctrl.writeAluOut = 1'b1; // PC - 4 rewinds past break
                    ctrl.aluSrcB     = ctrlPkg::srcFour;
                    ctrl.aluCtrl     = ctrlPkg::aluSub;
                end else begin
                    ctrl.writePc = 1'b1;
                end
            end
            default: begin
                // Traps drive nothing
            end
        endcase
    end

    noInstrPcOverlap: assert property (@(posedge ctrl.clk)
        !(ctrl.writeInstr && ctrl.writePc));

endmodule

`default_nettype wire

//--- control/stepCounter.sv
`timescale 1ns/1ps
`default_nettype none

module stepCounter (
    input  wire logic                              clk,
    input  wire logic                              reset,
    input  wire ctrlPkg::ctrlState_t               state,
    input  wire ctrlPkg::ctrlState_t               nextState,
    output logic [ctrlPkg::STEP_WIDTH-1:0]         step,
    output logic                                   stepLast
);

    logic [ctrlPkg::STEP_WIDTH-1:0] lastStep;

    // Final step index per state
    always_comb begin
        case (state)
            ctrlPkg::stFetch: lastStep = ctrlPkg::STEP_WIDTH'(ctrlPkg::FETCH_STEPS - 1);
            ctrlPkg::stSll:   lastStep = ctrlPkg::STEP_WIDTH'(ctrlPkg::SLL_STEPS - 1);
            ctrlPkg::stBreak: lastStep = ctrlPkg::STEP_WIDTH'(ctrlPkg::BREAK_STEPS - 1);
            default:          lastStep = '0;
        endcase
    end

    assign stepLast = (step == lastStep);

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= '0;
        end else if ((nextState != state) || stepLast) begin
            step <= '0; // Terminal states sit at step 0
        end else begin
            step <= step + 1'b1;
        end
    end

    stepInRange: assert property (@(posedge clk) disable iff (reset) step <= lastStep);

endmodule

`default_nettype wire

//--- logic/ctrlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlUnit (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [5:0] opcode,
    input  wire logic [5:0] funct,
    input  wire logic       overflow,
    output logic            writePc,
    output logic            writeA,
    output logic            writeB,
    output logic            writeAluOut,
    output logic            writeInstr,
    output logic            writeReg,
    output logic [2:0]      aluCtrl,
    output logic [1:0]      aluSrcA,
    output logic [2:0]      aluSrcB,
    output logic [1:0]      regDst,
    output logic [2:0]      dataSrc,
    output logic [2:0]      shiftCtrl,
    output logic [1:0]      shiftNCtrl,
    output logic            overflowTrap,
    output logic            opcodeError
);

    ctrlPkg::instrClass_t           instrClass;
    ctrlPkg::ctrlState_t            state;
    ctrlPkg::ctrlState_t            nextState;
    logic [ctrlPkg::STEP_WIDTH-1:0] step;
    logic                           stepLast;

    datapathCtrlIf ctrl (.clk(clk));

    instrDecoder u_instrDecoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    ctrlFsm u_ctrlFsm (
        .clk          (clk),
        .reset        (reset),
        .instrClass   (instrClass),
        .overflow     (overflow),
        .stepLast     (stepLast),
        .state        (state),
        .nextState    (nextState),
        .overflowTrap (overflowTrap),
        .opcodeError  (opcodeError)
    );

    stepCounter u_stepCounter (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .nextState (nextState),
        .step      (step),
        .stepLast  (stepLast)
    );

    ctrlOutputs u_ctrlOutputs (
        .state (state),
        .step  (step),
        .ctrl  (ctrl.source)
    );

    // Control word out to plain ports
    assign writePc     = ctrl.writePc;
    assign writeA      = ctrl.writeA;
    assign writeB      = ctrl.writeB;
    assign writeAluOut = ctrl.writeAluOut;
    assign writeInstr  = ctrl.writeInstr;
    assign writeReg    = ctrl.writeReg;
    assign aluCtrl     = ctrl.aluCtrl;
    assign aluSrcA     = ctrl.aluSrcA;
    assign aluSrcB     = ctrl.aluSrcB;
    assign regDst      = ctrl.regDst;
    assign dataSrc     = ctrl.dataSrc;
    assign shiftCtrl   = ctrl.shiftCtrl;
    assign shiftNCtrl  = ctrl.shiftAmtSrc; // Shift amount select

endmodule

`default_nettype wire

//--- logic/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  wire logic [5:0]           opcode,
    input  wire logic [5:0]           funct,
    output ctrlPkg::instrClass_t      instrClass
);

    ctrlPkg::instrClass_t functClass;

    // R-type group selected by funct
    always_comb begin
        case (funct)
            ctrlPkg::fnAdd:   functClass = ctrlPkg::clsAdd;
            ctrlPkg::fnSub:   functClass = ctrlPkg::clsSub;
            ctrlPkg::fnAnd:   functClass = ctrlPkg::clsAnd;
            ctrlPkg::fnSll:   functClass = ctrlPkg::clsSll;
            ctrlPkg::fnMfhi:  functClass = ctrlPkg::clsMfhi;
            ctrlPkg::fnMflo:  functClass = ctrlPkg::clsMflo;
            ctrlPkg::fnBreak: functClass = ctrlPkg::clsBreak;
            default:          functClass = ctrlPkg::clsIllegal;
        endcase
    end

    always_comb begin
        case (opcode)
            ctrlPkg::opTypeR: instrClass = functClass;
            ctrlPkg::opAddi:  instrClass = ctrlPkg::clsAddi;
            ctrlPkg::opAddiu: instrClass = ctrlPkg::clsAddiu;
            default:          instrClass = ctrlPkg::clsIllegal; // Unsupported opcode
        endcase
    end

endmodule

`default_nettype wire

//--- src.f
common/ctrlPkg.sv
common/datapathCtrlIf.sv
logic/instrDecoder.sv
control/stepCounter.sv
control/ctrlFsm.sv
control/ctrlOutputs.sv
logic/ctrlUnit.sv
testbench/clockGen.sv
testbench/ctrlUnitTb.sv

//--- testbench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Power-up reset
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/ctrlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlUnitTb;

    localparam int NUM_INSTR    = 200;
    localparam int RESET_CYCLES = 8;
    localparam int TRAP_HOLD    = 2;
    // 12 cycles per instruction, 20 traps of 9 extra cycles, plus slack
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 12 + 20 * 9 + 100;

    typedef enum int {
        mResetInit, mFetch, mPrecalc, mPrecalc2, mAdd, mSub, mAnd, mSaveResult,
        mAddi, mAddiu, mImmWriteBack, mSll, mMfhi, mMflo, mBreak, mOverflow, mOpcodeError
    } modelState_t;

    logic       clk;
    logic       porReset;
    logic       holdReset;
    logic       dutReset;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       overflow;
    logic       writePc, writeA, writeB, writeAluOut, writeInstr, writeReg;
    logic [2:0] aluCtrl, aluSrcB, dataSrc, shiftCtrl;
    logic [1:0] aluSrcA, regDst, shiftNCtrl;
    logic       overflowTrap, opcodeError;

    // Expected control word
    logic       eWritePc, eWriteA, eWriteB, eWriteAluOut, eWriteInstr, eWriteReg;
    logic [2:0] eAluCtrl, eAluSrcB, eDataSrc, eShiftCtrl;
    logic [1:0] eAluSrcA, eRegDst, eShiftN;
    logic       eOverflowTrap, eOpcodeError;

    logic [31:0] seed;
    modelState_t mState;
    int          mStep;
    modelState_t curTarget;
    string       testName;
    int          testErrors;
    int          passCount;
    int          failCount;
    int          cycleCount;
    logic [5:0]  tableOpcode [9];
    logic [5:0]  tableFunct [9];
    modelState_t tableTarget [9];
    string       tableName [9];
    logic [5:0]  newOpcode;
    logic [5:0]  newFunct;

    assign dutReset = porReset | holdReset;

    clockGen u_clockGen (
        .clk   (clk),
        .reset (porReset)
    );

    ctrlUnit u_ctrlUnit (
        .clk          (clk),
        .reset        (dutReset),
        .opcode       (opcode),
        .funct        (funct),
        .overflow     (overflow),
        .writePc      (writePc),
        .writeA       (writeA),
        .writeB       (writeB),
        .writeAluOut  (writeAluOut),
        .writeInstr   (writeInstr),
        .writeReg     (writeReg),
        .aluCtrl      (aluCtrl),
        .aluSrcA      (aluSrcA),
        .aluSrcB      (aluSrcB),
        .regDst       (regDst),
        .dataSrc      (dataSrc),
        .shiftCtrl    (shiftCtrl),
        .shiftNCtrl   (shiftNCtrl),
        .overflowTrap (overflowTrap),
        .opcodeError  (opcodeError)
    );

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {16'h0000, seed[31:16]}; // Low LCG bits are weak
    endfunction

    function automatic bit isKnownFunct(input logic [5:0] code);
        return code inside {6'h00, 6'h0d, 6'h10, 6'h12, 6'h20, 6'h22, 6'h24};
    endfunction

    function automatic int stepsIn(input modelState_t st);
        case (st)
            mFetch:  return 4;
            mSll:    return 3;
            mBreak:  return 2;
            default: return 1;
        endcase
    endfunction

    task automatic setEntry(input int idx, input logic [5:0] op, input logic [5:0] fn,
                            input modelState_t target, input string name);
        tableOpcode[idx] = op;
        tableFunct[idx]  = fn;
        tableTarget[idx] = target;
        tableName[idx]   = name;
    endtask

    task automatic setExpected;
        eWritePc      = 1'b0;
        eWriteA       = 1'b0;
        eWriteB       = 1'b0;
        eWriteAluOut  = 1'b0;
        eWriteInstr   = 1'b0;
        eWriteReg     = 1'b0;
        eAluCtrl      = ctrlPkg::aluPass;
        eAluSrcA      = ctrlPkg::srcPc;
        eAluSrcB      = ctrlPkg::srcRegB;
        eRegDst       = ctrlPkg::dstRd;
        eDataSrc      = ctrlPkg::dataAluOut;
        eShiftCtrl    = ctrlPkg::shiftHold;
        eShiftN       = ctrlPkg::amtNone;
        eOverflowTrap = (mState == mOverflow);
        eOpcodeError  = (mState == mOpcodeError);
        case (mState)
            mResetInit: begin
                eWriteReg = 1'b1;
                eRegDst   = ctrlPkg::dstStackPtr;
                eDataSrc  = ctrlPkg::dataStackInit;
            end
            mFetch: begin
                if (mStep == 3) begin
                    eWritePc = 1'b1;
                end else begin
                    eWriteInstr  = 1'b1;
                    eWriteAluOut = 1'b1;
                    eAluSrcB     = ctrlPkg::srcFour; // PC + 4
                    eAluCtrl     = ctrlPkg::aluAdd;
                end
            end
            mPrecalc: begin
                eWriteAluOut = 1'b1;
                eAluSrcB     = ctrlPkg::srcBranchOff;
                eAluCtrl     = ctrlPkg::aluAdd;
            end
            mPrecalc2: begin
                eWriteA = 1'b1;
                eWriteB = 1'b1;
            end
            mAdd, mSub, mAnd: begin
                eWriteAluOut = 1'b1;
                eAluSrcA     = ctrlPkg::srcRegA;
                eAluCtrl     = (mState == mAdd) ? ctrlPkg::aluAdd :
                               (mState == mSub) ? ctrlPkg::aluSub : ctrlPkg::aluAnd;
            end
            mAddi, mAddiu: begin
                eWriteAluOut = 1'b1;
                eAluSrcA     = ctrlPkg::srcRegA;
                eAluSrcB     = ctrlPkg::srcSignImm;
                eAluCtrl     = ctrlPkg::aluAdd;
            end
            mSaveResult: eWriteReg = 1'b1;
            mImmWriteBack: begin
                eWriteReg = 1'b1;
                eRegDst   = ctrlPkg::dstRt;
            end
            mSll: begin
                eAluCtrl   = ctrlPkg::aluShiftPass;
                eShiftN    = ctrlPkg::amtShamt;
                eShiftCtrl = (mStep == 0) ? ctrlPkg::shiftLoad : ctrlPkg::shiftLeft;
                if (mStep == 2) begin
                    eWriteReg = 1'b1;
                    eDataSrc  = ctrlPkg::dataShifter;
                end
            end
            mMfhi, mMflo: begin
                eWriteReg = 1'b1;
                eDataSrc  = (mState == mMfhi) ? ctrlPkg::dataHi : ctrlPkg::dataLo;
            end
            mBreak: begin
                if (mStep == 0) begin
                    eWriteAluOut = 1'b1; // PC - 4
                    eAluSrcB     = ctrlPkg::srcFour;
                    eAluCtrl     = ctrlPkg::aluSub;
                end else begin
                    eWritePc = 1'b1;
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic checkField(input string name, input logic [2:0] expVal,
                              input logic [2:0] actVal);
        assert (actVal === expVal) else begin
            $display("mismatch %s expected %h actual %h (model state %s step %0d)",
                     name, expVal, actVal, mState.name(), mStep);
            testErrors++;
        end
    endtask

    task automatic checkOutputs;
        setExpected();
        checkField("writePc", eWritePc, writePc);
        checkField("writeA", eWriteA, writeA);
        checkField("writeB", eWriteB, writeB);
        checkField("writeAluOut", eWriteAluOut, writeAluOut);
        checkField("writeInstr", eWriteInstr, writeInstr);
        checkField("writeReg", eWriteReg, writeReg);
        checkField("aluCtrl", eAluCtrl, aluCtrl);
        checkField("aluSrcA", eAluSrcA, aluSrcA);
        checkField("aluSrcB", eAluSrcB, aluSrcB);
        checkField("regDst", eRegDst, regDst);
        checkField("dataSrc", eDataSrc, dataSrc);
        checkField("shiftCtrl", eShiftCtrl, shiftCtrl);
        checkField("shiftNCtrl", eShiftN, shiftNCtrl);
        checkField("overflowTrap", eOverflowTrap, overflowTrap);
        checkField("opcodeError", eOpcodeError, opcodeError);
    endtask

    task automatic advanceModel(input logic sampledReset, input logic sampledOverflow);
        modelState_t next;
        bit          isLast;
        isLast = (mStep == stepsIn(mState) - 1);
        next   = mState;
        case (mState)
            mResetInit:    next = mFetch;
            mFetch:        next = isLast ? mPrecalc : mFetch;
            mPrecalc:      next = mPrecalc2;
            mPrecalc2:     next = curTarget;
            mAdd, mSub, mAnd: next = mSaveResult;
            mSaveResult:   next = sampledOverflow ? mOverflow : mFetch;
            mAddi:         next = sampledOverflow ? mOverflow : mImmWriteBack;
            mAddiu:        next = mImmWriteBack;
            mSll, mBreak:  next = isLast ? mFetch : mState;
            mImmWriteBack, mMfhi, mMflo: next = mFetch;
            default:       next = mState; // Traps hold
        endcase
        if (sampledReset) begin
            mState = mResetInit;
            mStep  = 0;
        end else begin
            mStep  = (next == mState && !isLast) ? mStep + 1 : 0;
            mState = next;
        end
    endtask

    // One clock: check mid-cycle, then step the model on the edge
    task automatic runCycle;
        logic sampledReset;
        logic sampledOverflow;
        @(negedge clk);
        checkOutputs();
        sampledReset    = dutReset;
        sampledOverflow = overflow;
        @(posedge clk);
        advanceModel(sampledReset, sampledOverflow);
    endtask

    task automatic runToFetch;
        int trapCycles;
        int resetCycles;
        trapCycles  = 0;
        resetCycles = 0;
        do begin
            runCycle();
            overflow <= (nextRand() % 4 == 0);
            if (holdReset) begin
                resetCycles++;
                if (resetCycles == RESET_CYCLES) begin
                    holdReset <= 1'b0;
                end
            end else if (mState == mOverflow || mState == mOpcodeError) begin
                trapCycles++;
                if (trapCycles == TRAP_HOLD) begin
                    holdReset <= 1'b1; // Only reset leaves a trap
                end
            end
        end while (!(mState == mFetch && mStep == 0));
    endtask

    task automatic pickInstr(output logic [5:0] op, output logic [5:0] fn);
        int roll;
        int pick;
        roll = nextRand() % 10;
        pick = -1;
        if (roll < 8) begin
            pick = nextRand() % 9;
        end else if (roll == 8) begin
            pick = nextRand() % 4; // add, sub, and, addi
            if (pick == 3) begin
                pick = 7;
            end
        end
        if (pick < 0) begin
            if (nextRand() % 2 == 0) begin
                op = 6'(nextRand());
                while (op inside {6'h00, 6'h08, 6'h09}) begin
                    op = 6'(nextRand());
                end
                fn = 6'(nextRand());
            end else begin
                op = 6'h00;
                fn = 6'(nextRand());
                while (isKnownFunct(fn)) begin
                    fn = 6'(nextRand());
                end
            end
            curTarget = mOpcodeError;
            testName  = $sformatf("illegal op %h fn %h", op, fn);
        end else begin
            op        = tableOpcode[pick];
            fn        = (op == 6'h00) ? tableFunct[pick] : 6'(nextRand());
            curTarget = tableTarget[pick];
            testName  = tableName[pick];
        end
    endtask

    task automatic reportTest(input int idx);
        if (testErrors == 0) begin
            passCount++;
            $display("test %0d %s ok", idx, testName);
        end else begin
            failCount++;
            $display("test %0d %s FAILED with %0d errors", idx, testName, testErrors);
        end
        testErrors = 0;
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, instruction stream did not finish", cycleCount);
        $display("Test failures found");
        $finish;
    end

    initial begin
        seed       = 32'h9da7_a092;
        opcode     = 6'h00;
        funct      = 6'h00;
        overflow   = 1'b0;
        holdReset  = 1'b0;
        mState     = mResetInit;
        mStep      = 0;
        curTarget  = mOpcodeError;
        testErrors = 0;
        passCount  = 0;
        failCount  = 0;
        testName   = "power-up reset";
        // MIPS encodings
        setEntry(0, 6'h00, 6'h20, mAdd, "add");
        setEntry(1, 6'h00, 6'h22, mSub, "sub");
        setEntry(2, 6'h00, 6'h24, mAnd, "and");
        setEntry(3, 6'h00, 6'h00, mSll, "sll");
        setEntry(4, 6'h00, 6'h10, mMfhi, "mfhi");
        setEntry(5, 6'h00, 6'h12, mMflo, "mflo");
        setEntry(6, 6'h00, 6'h0d, mBreak, "break");
        setEntry(7, 6'h08, 6'h00, mAddi, "addi");
        setEntry(8, 6'h09, 6'h00, mAddiu, "addiu");
        @(posedge clk); // State is defined from here on
        for (int idx = 0; idx <= NUM_INSTR; idx++) begin
            runToFetch();
            reportTest(idx);
            if (idx < NUM_INSTR) begin
                pickInstr(newOpcode, newFunct);
                opcode <= newOpcode; // Held through decode
                funct  <= newFunct;
            end
        end
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
